// ==== source/busPkg.sv ====
package busPkg;

    ////////////////////////////////////////
    // control bus shape
    ////////////////////////////////////////
    localparam int ADDR_WIDTH_DEF = 6;   // top level default only
    localparam int DATA_WIDTH_DEF = 32;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////
    localparam int ENABLE_EQUALIZER = 4; // bit 0 enables the loop
    localparam int GAIN_CHAN0       = 6; // low 16 bits
    localparam int GAIN_CHAN1       = 7; // low 16 bits

endpackage

// ==== source/eqPkg.sv ====
package eqPkg;

    ////////////////////////////////////////
    // sample and gain words
    ////////////////////////////////////////
    typedef logic signed [15:0] sampleT;    // two's complement audio
    typedef logic        [15:0] rawSampleT; // offset binary, as the converters use
    typedef logic signed [15:0] gainT;      // 14 fraction bits

    typedef enum logic {
        CHAN0 = 1'b0,
        CHAN1 = 1'b1
    } chanT;

    ////////////////////////////////////////
    // converter words
    ////////////////////////////////////////
    typedef logic [15:0] adcCmdT;
    typedef logic [31:0] dacWordT;          // control word above, code below

    localparam adcCmdT ADC_CHAN_0 = 16'h8000;
    localparam adcCmdT ADC_CHAN_1 = 16'hC000;

    localparam logic [15:0] DAC_CTL_0 = 16'h0030; // load output A
    localparam logic [15:0] DAC_CTL_1 = 16'h0031; // load output B

    localparam rawSampleT SAMPLE_OFFSET = 16'h8000;
    localparam gainT      GAIN_UNITY    = 16'h4000;

endpackage

// ==== source/configRegs.sv ====
module configRegs import busPkg::*, eqPkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic                      wr,
    input  logic [ADDR_WIDTH-1:0]     wrAddr,
    input  logic [DATA_WIDTH_DEF-1:0] wrData,
    output logic                      enable,
    output gainT                      gain0,
    output gainT                      gain1
);

    ////////////////////////////////////////
    // write decode
    ////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            enable <= 1'b0;
            gain0  <= GAIN_UNITY;
            gain1  <= GAIN_UNITY;
        end else if (wr) begin
            case (wrAddr)
                ADDR_WIDTH'(ENABLE_EQUALIZER): begin
                    enable <= wrData[0];
                end
                ADDR_WIDTH'(GAIN_CHAN0): begin
                    gain0 <= gainT'(wrData[15:0]);
                end
                ADDR_WIDTH'(GAIN_CHAN1): begin
                    gain1 <= gainT'(wrData[15:0]);
                end
                default: begin
                end                                // unmapped addresses dropped
            endcase
        end
    end

    // the loop only starts or stops through a bus write
    enableOnlyByWrite: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $past(S_AXI_ARESETN) && !$past(wr) |-> $stable(enable));

endmodule

// ==== source/reqAckMaster.sv ====
module reqAckMaster #(
    parameter type payloadT = logic [15:0]
) (
    input  logic    S_AXI_ACLK,
    input  logic    S_AXI_ARESETN,
    input  logic    start,
    input  payloadT payload,
    input  logic    ack,
    output logic    req,
    output payloadT reqPayload,
    output logic    done
);

    typedef enum logic [1:0] {IDLE, REQUEST, RELEASE} phaseT;

    phaseT phase;

    ////////////////////////////////////////
    // handshake phases
    ////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            phase <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (phase)
                IDLE: if (start) phase <= REQUEST;
                REQUEST: if (ack) phase <= RELEASE;     // responder took it
                RELEASE: begin
                    if (!ack) begin
                        phase <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (phase == IDLE && start) reqPayload <= payload; // held for the whole request
    end

    assign req = (phase == REQUEST);

    reqHeldUntilAck: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        req && !ack |=> req);

    payloadStableInReq: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        req && $past(req) |-> $stable(reqPayload));

endmodule

// ==== source/gainStage.sv ====
module gainStage import eqPkg::*; #(
    parameter int GAIN_FRAC_BITS = 14
) (
    input  logic   S_AXI_ACLK,
    input  logic   S_AXI_ARESETN,
    input  logic   gainValidIn,
    input  sampleT gainSample,
    input  gainT   gainCoef,
    output logic   gainValidOut,
    output sampleT gainResult
);

    localparam logic signed [31:0] SAT_MAX = 32'sd32767;
    localparam logic signed [31:0] SAT_MIN = -32'sd32768;

    logic               validStage1;
    logic signed [31:0] product;
    logic signed [31:0] shifted;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            validStage1  <= 1'b0;
            gainValidOut <= 1'b0;
        end else begin
            validStage1  <= gainValidIn;
            gainValidOut <= validStage1;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        product <= gainSample * gainCoef;             // full precision
        if (shifted > SAT_MAX) gainResult <= sampleT'(SAT_MAX);
        else if (shifted < SAT_MIN) gainResult <= sampleT'(SAT_MIN);
        else gainResult <= sampleT'(shifted);
    end

    assign shifted = product >>> GAIN_FRAC_BITS;      // drop the gain fraction

endmodule

// ==== source/sampleSequencer.sv ====
module sampleSequencer import eqPkg::*; (
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,
    input  logic      enable,
    input  gainT      gain0,
    input  gainT      gain1,
    input  logic      adcDone,
    input  rawSampleT adcData,
    input  logic      dacDone,
    input  logic      gainValidOut,
    input  sampleT    gainResult,
    output logic      adcStart,
    output adcCmdT    adcPayload,
    output logic      dacStart,
    output dacWordT   dacPayload,
    output logic      gainValidIn,
    output sampleT    gainSample,
    output gainT      gainCoef
);

    typedef enum logic [2:0] {IDLE, ADC, GAIN, DAC, NEXT} seqStateT;

    seqStateT    state;
    chanT        chan;
    sampleT      sampleReg;
    rawSampleT   dacCode;
    logic [15:0] dacCtl;

    ////////////////////////////////////////
    // channel dependent words
    ////////////////////////////////////////
    always_comb begin
        if (chan == CHAN0) begin
            adcPayload = ADC_CHAN_0;
            dacCtl     = DAC_CTL_0;
            gainCoef   = gain0;
        end else begin
            adcPayload = ADC_CHAN_1;
            dacCtl     = DAC_CTL_1;
            gainCoef   = gain1;
        end
    end

    assign dacCode    = rawSampleT'(gainResult) + SAMPLE_OFFSET; // back to offset binary
    assign dacPayload = {dacCtl, dacCode};
    assign gainSample = sampleReg;

    // one-cycle start pulses, the masters latch the payload
    assign adcStart = enable && (state == IDLE || state == NEXT);
    assign dacStart = (state == GAIN) && gainValidOut;

    ////////////////////////////////////////
    // sample loop
    ////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state       <= IDLE;
            chan        <= CHAN0;
            gainValidIn <= 1'b0;
        end else begin
            gainValidIn <= 1'b0;
            case (state)
                IDLE: begin
                    if (enable) state <= ADC;
                end
                ADC: begin
                    if (adcDone) begin
                        state       <= GAIN;
                        gainValidIn <= 1'b1;           // sampleReg loads on the same edge
                    end
                end
                GAIN: begin
                    if (gainValidOut) state <= DAC;
                end
                DAC: begin
                    if (dacDone) begin
                        chan  <= (chan == CHAN0) ? CHAN1 : CHAN0;
                        state <= NEXT;
                    end
                end
                NEXT: begin
                    state <= enable ? ADC : IDLE;    // disable lands here, channel kept
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (state == ADC && adcDone) begin
            sampleReg <= sampleT'(adcData - SAMPLE_OFFSET); // to signed
        end
    end

    noOverlappingStarts: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(adcStart && dacStart));

endmodule

// ==== source/eqController.sv ====
module eqController import busPkg::*, eqPkg::*; #(
    parameter int ADDR_WIDTH     = ADDR_WIDTH_DEF,
    parameter int GAIN_FRAC_BITS = 14
) (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic                      wr,
    input  logic [ADDR_WIDTH-1:0]     wrAddr,
    input  logic [DATA_WIDTH_DEF-1:0] wrData,
    output logic                      adcReq,
    output adcCmdT                    adcCmd,
    input  logic                      adcAck,
    input  rawSampleT                 adcData,
    output logic                      dacReq,
    output dacWordT                   dacWord,
    input  logic                      dacAck
);

    logic    enable;
    gainT    gain0, gain1;
    logic    adcStart, adcDone, dacStart, dacDone;
    adcCmdT  adcPayload;
    dacWordT dacPayload;
    logic    gainValidIn, gainValidOut;
    sampleT  gainSample, gainResult;
    gainT    gainCoef;

    ////////////////////////////////////////
    // control and sequencing
    ////////////////////////////////////////
    configRegs #(.ADDR_WIDTH(ADDR_WIDTH)) regs (
        .S_AXI_ACLK, .S_AXI_ARESETN, .wr, .wrAddr, .wrData,
        .enable, .gain0, .gain1
    );

    sampleSequencer seq (
        .S_AXI_ACLK, .S_AXI_ARESETN, .enable, .gain0, .gain1,
        .adcDone, .adcData, .dacDone, .gainValidOut, .gainResult,
        .adcStart, .adcPayload, .dacStart, .dacPayload,
        .gainValidIn, .gainSample, .gainCoef
    );

    gainStage #(.GAIN_FRAC_BITS(GAIN_FRAC_BITS)) gain (
        .S_AXI_ACLK, .S_AXI_ARESETN, .gainValidIn, .gainSample, .gainCoef,
        .gainValidOut, .gainResult
    );

    ////////////////////////////////////////
    // converter handshakes
    ////////////////////////////////////////
    reqAckMaster #(.payloadT(adcCmdT)) adcMaster (
        .S_AXI_ACLK, .S_AXI_ARESETN, .start(adcStart), .payload(adcPayload),
        .ack(adcAck), .req(adcReq), .reqPayload(adcCmd), .done(adcDone)
    );

    reqAckMaster #(.payloadT(dacWordT)) dacMaster (
        .S_AXI_ACLK, .S_AXI_ARESETN, .start(dacStart), .payload(dacPayload),
        .ack(dacAck), .req(dacReq), .reqPayload(dacWord), .done(dacDone)
    );

endmodule

// ==== test/eqChecker.sv ====
module eqChecker import busPkg::*, eqPkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic                      wr,
    input  logic [ADDR_WIDTH-1:0]     wrAddr,
    input  logic [DATA_WIDTH_DEF-1:0] wrData,
    input  logic [63:0]               testName,
    input  logic                      adcReq,
    input  adcCmdT                    adcCmd,
    input  logic                      adcAck,
    input  rawSampleT                 adcData,
    input  logic                      dacReq,
    input  dacWordT                   dacWord,
    input  logic                      dacAck,
    output int                        mismatchCount,
    output int                        protocolCount
);

    logic [15:0] gainModel [2];
    logic        enableModel;
    logic        chanModel;
    logic        prevAdcReq, prevAdcAck, prevDacReq, prevDacAck;
    adcCmdT      prevAdcCmd;
    dacWordT     prevDacWord;
    dacWordT     expectedWords [$];
    dacWordT     expWord;

    // offset binary in, scaled and saturated, offset binary out
    function automatic logic [15:0] scaleCode(input logic [15:0] raw, input logic [15:0] gain);
        logic signed [31:0] centered;
        logic signed [31:0] scaled;
        centered = $signed({16'h0000, raw}) - 32'sh8000;
        scaled   = (centered * $signed({{16{gain[15]}}, gain})) >>> 14;
        if (scaled > 32'sd32767) scaled = 32'sd32767;
        if (scaled < -32'sd32768) scaled = -32'sd32768;
        return scaled[15:0] + 16'h8000;
    endfunction

    ////////////////////////////////////////
    // model of the register writes
    ////////////////////////////////////////
    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gainModel[0] <= 16'h4000;
            gainModel[1] <= 16'h4000;
            enableModel  <= 1'b0;
        end else if (wr) begin
            if (wrAddr == ADDR_WIDTH'(ENABLE_EQUALIZER)) enableModel <= wrData[0];
            if (wrAddr == ADDR_WIDTH'(GAIN_CHAN0)) gainModel[0] <= wrData[15:0];
            if (wrAddr == ADDR_WIDTH'(GAIN_CHAN1)) gainModel[1] <= wrData[15:0];
        end
    end

    ////////////////////////////////////////
    // transfers and handshake rules
    ////////////////////////////////////////
    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            chanModel     <= 1'b0;
            mismatchCount <= 0;
            protocolCount <= 0;
            expectedWords.delete();
        end else begin
            if (adcReq && !prevAdcReq && !enableModel) begin
                $display("Error: adcReq rose while the controller was disabled");
                protocolCount <= protocolCount + 1;
            end
            if (adcReq && adcAck) begin                // one edge per ADC transfer
                if (adcCmd !== (chanModel ? 16'hC000 : 16'h8000)) begin
                    $display("Mismatch %0s: expected %h, actual %h", testName,
                        chanModel ? 16'hC000 : 16'h8000, adcCmd);
                    mismatchCount <= mismatchCount + 1;
                end
                expectedWords.push_back({chanModel ? 16'h0031 : 16'h0030,
                    scaleCode(adcData, gainModel[chanModel])});
                chanModel <= !chanModel;
            end
            if (dacReq && dacAck) begin
                if (expectedWords.size() == 0) begin
                    $display("Error: DAC write with no ADC sample before it");
                    protocolCount <= protocolCount + 1;
                end else begin
                    expWord = expectedWords.pop_front();
                    if (dacWord !== expWord) begin
                        $display("Mismatch %0s: expected %h, actual %h", testName,
                            expWord, dacWord);
                        mismatchCount <= mismatchCount + 1;
                    end
                end
            end
            if ((prevAdcReq && !adcReq && !prevAdcAck) ||
                (prevDacReq && !dacReq && !prevDacAck)) begin
                $display("Error: a request dropped before its acknowledge rose");
                protocolCount <= protocolCount + 1;
            end
            if ((prevAdcReq && adcReq && adcCmd !== prevAdcCmd) ||
                (prevDacReq && dacReq && dacWord !== prevDacWord)) begin
                $display("Error: a payload changed while its request was high");
                protocolCount <= protocolCount + 1;
            end
        end
        prevAdcReq  <= adcReq;
        prevAdcAck  <= adcAck;
        prevDacReq  <= dacReq;
        prevDacAck  <= dacAck;
        prevAdcCmd  <= adcCmd;
        prevDacWord <= dacWord;
    end

endmodule

// ==== test/eqControllerTb.sv ====
module eqControllerTb import busPkg::*, eqPkg::*;;

    localparam int ADDR_WIDTH = 6;
    localparam int TIMEOUT    = 200;  // cycles per wait
    localparam int ROWS       = 4;

    logic                      S_AXI_ACLK;
    logic                      S_AXI_ARESETN;
    logic                      wr;
    logic [ADDR_WIDTH-1:0]     wrAddr;
    logic [DATA_WIDTH_DEF-1:0] wrData;
    logic                      adcReq, adcAck, dacReq, dacAck;
    adcCmdT                    adcCmd;
    rawSampleT                 adcData;
    dacWordT                   dacWord;
    logic [63:0]               testName;
    int                        mismatchCount, protocolCount;
    int                        quietErrors;
    int                        seed;
    logic                      timedOut;

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////
    logic [63:0] names   [ROWS] = '{"unity", "half", "satHigh", "satLow"};
    logic [15:0] gains0  [ROWS] = '{16'h4000, 16'h2000, 16'h7FFF, 16'h7FFF};
    logic [15:0] gains1  [ROWS] = '{16'h4000, 16'hC000, 16'h7FFF, 16'h8000};
    logic [15:0] samples [ROWS][4] = '{
        '{16'h1234, 16'h8000, 16'hFFFF, 16'h0000},
        '{16'hA000, 16'h6000, 16'h9000, 16'h7000},
        '{16'hF000, 16'hFFFF, 16'hC000, 16'h8100}, // pushes past the top
        '{16'h1000, 16'h9000, 16'h0000, 16'hF000}  // and past the bottom
    };

    eqController #(.ADDR_WIDTH(ADDR_WIDTH), .GAIN_FRAC_BITS(14)) uut (
        .S_AXI_ACLK, .S_AXI_ARESETN, .wr, .wrAddr, .wrData,
        .adcReq, .adcCmd, .adcAck, .adcData, .dacReq, .dacWord, .dacAck
    );

    eqChecker #(.ADDR_WIDTH(ADDR_WIDTH)) scoreboard (
        .S_AXI_ACLK, .S_AXI_ARESETN, .wr, .wrAddr, .wrData, .testName,
        .adcReq, .adcCmd, .adcAck, .adcData, .dacReq, .dacWord, .dacAck,
        .mismatchCount, .protocolCount
    );

    always #20 S_AXI_ACLK = !S_AXI_ACLK;

    task automatic nextCycle();
        @(posedge S_AXI_ACLK);
        #5;                                    // drive away from the edge
    endtask

    task automatic busWrite(input int addr, input logic [31:0] data);
        wr     = 1'b1;
        wrAddr = ADDR_WIDTH'(addr);
        wrData = data;
        nextCycle();
        wr = 1'b0;
    endtask

    task automatic randomDelay();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) nextCycle();
    endtask

    task automatic waitReq(input logic isDac, input logic level);
        int n;
        n = 0;
        while (!timedOut && (isDac ? dacReq : adcReq) !== level && n < TIMEOUT) begin
            nextCycle();
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Error: timed out waiting for %0s to go %0d",
                isDac ? "dacReq" : "adcReq", level);
            timedOut = 1'b1;
        end
    endtask

    // ack follows req after a random delay on both edges
    task automatic serveAdc(input logic [15:0] sample);
        waitReq(1'b0, 1'b1);
        randomDelay();
        adcData = sample;
        adcAck  = 1'b1;
        waitReq(1'b0, 1'b0);
        randomDelay();
        adcAck = 1'b0;
    endtask

    task automatic serveDac();
        waitReq(1'b1, 1'b1);
        randomDelay();
        dacAck = 1'b1;
        waitReq(1'b1, 1'b0);
        randomDelay();
        dacAck = 1'b0;
    endtask

    task automatic checkQuiet(input int cycles);
        repeat (cycles) begin
            if (adcReq || dacReq) begin
                $display("Error: a converter request was raised while disabled");
                quietErrors++;
            end
            nextCycle();
        end
    endtask

    initial begin
        S_AXI_ACLK    = 1'b0;
        S_AXI_ARESETN = 1'b0;
        wr            = 1'b0;
        wrAddr        = '0;
        wrData        = '0;
        adcAck        = 1'b0;
        adcData       = '0;
        dacAck        = 1'b0;
        testName      = "reset";
        quietErrors   = 0;
        seed          = 33933;
        timedOut      = 1'b0;
        repeat (10) nextCycle();
        S_AXI_ARESETN = 1'b1;
        checkQuiet(10);
        for (int r = 0; r < ROWS; r++) begin
            testName = names[r];
            busWrite(GAIN_CHAN0, {16'h0000, gains0[r]});
            busWrite(GAIN_CHAN1, {16'h0000, gains1[r]});
            busWrite(ENABLE_EQUALIZER, 32'd1);
            for (int k = 0; k < 4; k++) begin
                serveAdc(samples[r][k]);
                if (k == 3) busWrite(ENABLE_EQUALIZER, 32'd0); // mid-sample disable
                serveDac();
            end
            checkQuiet(20);
        end
        $display("errors: mismatch %0d, protocol %0d, idle %0d, timeout %0d",
            mismatchCount, protocolCount, quietErrors, timedOut);
        if (mismatchCount == 0 && protocolCount == 0 && quietErrors == 0 && !timedOut) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/busPkg.sv
source/eqPkg.sv
source/configRegs.sv
source/reqAckMaster.sv
source/gainStage.sv
source/sampleSequencer.sv
source/eqController.sv
test/eqChecker.sv
test/eqControllerTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module eqControllerTb -o simv \
    && ./obj_dir/simv | grep -q "Simulation finished: PASS" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
